// ==== rtl/mem_sys_pkg.sv ====
package mem_sys_pkg;

    // line geometry
    localparam int LINE_BYTES  = 32;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES); // byte offset within a line

    // bmem burst geometry
    localparam int MEM_BURST_W = 64;
    localparam int BEATS       = (LINE_BYTES * 8) / MEM_BURST_W;

    // processor side word, also used for addresses
    typedef logic [31:0] word_t;

    // byte enables for one word, bit n covers byte n
    typedef logic [3:0] mask_t;

    // one cacheline, word 0 in the low bits
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // one bmem beat, beat 0 carries the low bits of the line
    typedef logic [MEM_BURST_W-1:0] beat_t;

endpackage : mem_sys_pkg

// ==== rtl/line_if.sv ====
`timescale 1ns/10ps

// cacheline request, level held by the client until the resp pulse
interface line_if;
    import mem_sys_pkg::*;

    word_t addr;   // line aligned
    logic  read;
    logic  write;
    line_t wdata;
    line_t rdata;
    logic  resp;   // one cycle

    // cache side, or the arbiter toward the adaptor
    modport client (
        output addr,
        output read,
        output write,
        output wdata,
        input  rdata,
        input  resp
    );

    // arbiter toward a cache, or the adaptor
    modport server (
        input  addr,
        input  read,
        input  write,
        input  wdata,
        output rdata,
        output resp
    );

endinterface : line_if

// ==== rtl/cache.sv ====
`timescale 1ns/10ps

module cache #(
    parameter int NUM_SETS = 8
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  mem_sys_pkg::word_t addr_i,
    input  logic               read_i,
    input  logic               write_i,
    input  mem_sys_pkg::mask_t wmask_i,
    input  mem_sys_pkg::word_t wdata_i,
    output mem_sys_pkg::word_t rdata_o,
    output logic               resp_o,
    line_if.client             mem
);
    import mem_sys_pkg::*;

    localparam int INDEX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS   = 32 - OFFSET_BITS - INDEX_BITS;
    localparam int WSEL_BITS  = OFFSET_BITS - 2; // word within line

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_FILL
    } state_t;

    state_t state_q;

    // one line per set
    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [TAG_BITS-1:0] tag_q [NUM_SETS];
    line_t               data_q [NUM_SETS];

    // registered request
    word_t addr_q;
    logic  write_q;
    mask_t wmask_q;
    word_t wdata_q;

    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    logic [WSEL_BITS-1:0]  wsel;
    logic                  hit;
    line_t                 merged;

    assign idx  = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign tag  = addr_q[OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    assign wsel = addr_q[2 +: WSEL_BITS];
    assign hit  = valid_q[idx] && (tag_q[idx] == tag);

    // store data merged into the resident line
    always_comb begin
        merged = data_q[idx];
        for (int b = 0; b < 4; b++) begin
            if (wmask_q[b]) begin
                merged[wsel * 32 + b * 8 +: 8] = wdata_q[b * 8 +: 8];
            end
        end
    end

    assign rdata_o = data_q[idx][wsel * 32 +: 32];
    assign resp_o  = (state_q == ST_COMPARE) && hit;

    // victim address on writeback, requested line on fill
    assign mem.read  = (state_q == ST_FILL);
    assign mem.write = (state_q == ST_WRITEBACK);
    assign mem.wdata = data_q[idx];
    assign mem.addr  = (state_q == ST_WRITEBACK) ?
                       {tag_q[idx], idx, {OFFSET_BITS{1'b0}}} :
                       {tag, idx, {OFFSET_BITS{1'b0}}};

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && (read_i || write_i)) begin
            addr_q  <= addr_i;
            write_q <= write_i;
            wmask_q <= wmask_i;
            wdata_q <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (read_i || write_i) begin
                        state_q <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    if (hit) begin
                        state_q <= ST_IDLE;
                        if (write_q) begin
                            dirty_q[idx] <= 1'b1;
                        end
                    end else if (valid_q[idx] && dirty_q[idx]) begin
                        state_q <= ST_WRITEBACK; // victim goes out first
                    end else begin
                        state_q <= ST_FILL;
                    end
                end
                ST_WRITEBACK: begin
                    if (mem.resp) begin
                        state_q <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (mem.resp) begin
                        state_q      <= ST_COMPARE; // answer from the array
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= 1'b0;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // line and tag arrays
    always_ff @(posedge clk) begin
        if (state_q == ST_FILL && mem.resp) begin
            data_q[idx] <= mem.rdata;
            tag_q[idx]  <= tag;
        end else if (state_q == ST_COMPARE && hit && write_q) begin
            data_q[idx] <= merged;
        end
    end

    a_cpu_rw_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(read_i && write_i))
        else $error("cache: read and write requested together");

    // the line side answers only a request that is still held
    a_mem_resp_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem.resp |-> (mem.read || mem.write))
        else $error("cache: line resp without a pending request");

endmodule : cache

// ==== rtl/cache_arbiter.sv ====
`timescale 1ns/10ps

module cache_arbiter (
    input  logic   clk,
    input  logic   rst_n_i,
    line_if.server icache,
    line_if.server dcache,
    line_if.client mem
);

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_I,
        GNT_D
    } grant_t;

    grant_t grant_q;
    grant_t sel;

    // new decision only while idle, data first
    always_comb begin
        sel = grant_q;
        if (grant_q == GNT_IDLE) begin
            if (dcache.read || dcache.write) begin
                sel = GNT_D;
            end else if (icache.read || icache.write) begin
                sel = GNT_I;
            end
        end
    end

    always_comb begin
        mem.addr  = icache.addr;
        mem.wdata = icache.wdata;
        mem.read  = 1'b0;
        mem.write = 1'b0;
        if (sel == GNT_D) begin
            mem.addr  = dcache.addr;
            mem.wdata = dcache.wdata;
            mem.read  = dcache.read;
            mem.write = dcache.write;
        end else if (sel == GNT_I) begin
            mem.read  = icache.read;
            mem.write = icache.write;
        end
    end

    assign icache.rdata = mem.rdata;
    assign dcache.rdata = mem.rdata;
    assign icache.resp  = mem.resp && (sel == GNT_I);
    assign dcache.resp  = mem.resp && (sel == GNT_D);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            grant_q <= GNT_IDLE;
        end else if (grant_q == GNT_IDLE) begin
            grant_q <= sel;
        end else if (mem.resp) begin
            grant_q <= GNT_IDLE; // held for the whole line transfer
        end
    end

    // adaptor answers only a transfer started under a held grant
    a_iresp_granted: assert property (@(posedge clk) disable iff (!rst_n_i)
        icache.resp |-> (grant_q == GNT_I))
        else $error("arbiter: icache resp without grant");

    a_dresp_granted: assert property (@(posedge clk) disable iff (!rst_n_i)
        dcache.resp |-> (grant_q == GNT_D))
        else $error("arbiter: dcache resp without grant");

endmodule : cache_arbiter

// ==== rtl/cacheline_adaptor.sv ====
`timescale 1ns/10ps

module cacheline_adaptor (
    input  logic               clk,
    input  logic               rst_n_i,
    line_if.server             line,
    output mem_sys_pkg::word_t bmem_addr_o,
    output logic               bmem_read_o,
    output logic               bmem_write_o,
    output mem_sys_pkg::beat_t bmem_wdata_o,
    input  mem_sys_pkg::beat_t bmem_rdata_i,
    input  logic               bmem_resp_i
);
    import mem_sys_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_DONE
    } state_t;

    state_t                     state_q;
    logic [$clog2(BEATS)-1:0]   beat_q;
    line_t                      buf_q;  // low beat goes out / comes in first
    word_t                      addr_q;

    assign bmem_addr_o  = addr_q;
    assign bmem_read_o  = (state_q == ST_READ);
    assign bmem_write_o = (state_q == ST_WRITE);
    assign bmem_wdata_o = buf_q[MEM_BURST_W-1:0];

    assign line.rdata = buf_q;
    assign line.resp  = (state_q == ST_DONE);

    // line buffer, one shift per beat in either direction
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE) begin
            addr_q <= line.addr;
            buf_q  <= line.wdata;
        end else if (bmem_resp_i) begin
            buf_q <= {bmem_rdata_i, buf_q[LINE_BYTES*8-1:MEM_BURST_W]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    beat_q <= '0;
                    if (line.read) begin
                        state_q <= ST_READ;
                    end else if (line.write) begin
                        state_q <= ST_WRITE;
                    end
                end
                ST_READ, ST_WRITE: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (int'(beat_q) == BEATS - 1) begin
                            state_q <= ST_DONE; // level drops here
                        end
                    end
                end
                ST_DONE: state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    a_no_idle_resp: assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_q == ST_IDLE) |-> !bmem_resp_i)
        else $error("adaptor: bmem resp while idle");

endmodule : cacheline_adaptor

// ==== rtl/mem_sys_top.sv ====
`timescale 1ns/10ps

module mem_sys_top #(
    parameter int NUM_SETS = 8
) (
    input  logic               clk,
    input  logic               rst_n_i,

    // fetch port
    input  mem_sys_pkg::word_t imem_addr_i,
    input  logic               imem_read_i,
    output mem_sys_pkg::word_t imem_rdata_o,
    output logic               imem_resp_o,

    // load/store port
    input  mem_sys_pkg::word_t dmem_addr_i,
    input  logic               dmem_read_i,
    input  logic               dmem_write_i,
    input  mem_sys_pkg::mask_t dmem_wmask_i,
    input  mem_sys_pkg::word_t dmem_wdata_i,
    output mem_sys_pkg::word_t dmem_rdata_o,
    output logic               dmem_resp_o,

    // burst memory
    output mem_sys_pkg::word_t bmem_addr_o,
    output logic               bmem_read_o,
    output logic               bmem_write_o,
    output mem_sys_pkg::beat_t bmem_wdata_o,
    input  mem_sys_pkg::beat_t bmem_rdata_i,
    input  logic               bmem_resp_i
);

    line_if icache_line ();
    line_if dcache_line ();
    line_if mem_line ();

    // fetch side never stores
    cache #(
        .NUM_SETS (NUM_SETS)
    ) icache0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr_i  (imem_addr_i),
        .read_i  (imem_read_i),
        .write_i (1'b0),
        .wmask_i ('0),
        .wdata_i ('0),
        .rdata_o (imem_rdata_o),
        .resp_o  (imem_resp_o),
        .mem     (icache_line.client)
    );

    cache #(
        .NUM_SETS (NUM_SETS)
    ) dcache0 (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr_i  (dmem_addr_i),
        .read_i  (dmem_read_i),
        .write_i (dmem_write_i),
        .wmask_i (dmem_wmask_i),
        .wdata_i (dmem_wdata_i),
        .rdata_o (dmem_rdata_o),
        .resp_o  (dmem_resp_o),
        .mem     (dcache_line.client)
    );

    cache_arbiter cache_arbiter (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .icache  (icache_line.server),
        .dcache  (dcache_line.server),
        .mem     (mem_line.client)
    );

    cacheline_adaptor cacheline_adaptor (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .line         (mem_line.server),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .bmem_rdata_i (bmem_rdata_i),
        .bmem_resp_i  (bmem_resp_i)
    );

endmodule : mem_sys_top

// ==== verif/burst_mem_model.sv ====
`timescale 1ns/10ps

// answers a held bmem request with four beats, one per cycle, lowest beat first
module burst_mem_model #(
    parameter int MEM_WORDS = 1024
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  mem_sys_pkg::word_t addr_i,
    input  logic               read_i,
    input  logic               write_i,
    input  mem_sys_pkg::beat_t wdata_i,
    output mem_sys_pkg::beat_t rdata_o,
    output logic               resp_o
);
    import mem_sys_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t mem [MEM_WORDS];   // filled by the testbench at time 0

    logic          resp_q  = 1'b0;
    beat_t         rdata_q = '0;
    logic [2:0]    beat_q  = '0;  // next beat to answer, 4 means burst done
    logic [1:0]    cur_q   = '0;  // beat of the resp now on the bus
    logic [AW-1:0] base;
    logic [AW-1:0] rd_lo;
    logic [AW-1:0] rd_hi;
    logic [AW-1:0] wr_lo;
    logic [AW-1:0] wr_hi;

    assign base  = addr_i[AW+1:2];
    assign rd_lo = {base[AW-1:3], beat_q[1:0], 1'b0};
    assign rd_hi = {base[AW-1:3], beat_q[1:0], 1'b1};
    assign wr_lo = {base[AW-1:3], cur_q, 1'b0};
    assign wr_hi = {base[AW-1:3], cur_q, 1'b1};

    assign resp_o  = resp_q;
    assign rdata_o = rdata_q;

    always @(posedge clk) begin
        if (!rst_n_i) begin
            resp_q <= 1'b0;
            beat_q <= '0;
            cur_q  <= '0;
        end else begin
            // write data is taken on the edge where the adaptor consumes the resp
            if (resp_q && write_i) begin
                mem[wr_lo] = wdata_i[31:0];
                mem[wr_hi] = wdata_i[63:32];
            end
            if ((read_i || write_i) && !beat_q[2]) begin
                resp_q  <= 1'b1;
                cur_q   <= beat_q[1:0];
                beat_q  <= beat_q + 3'd1;
                rdata_q <= {mem[rd_hi], mem[rd_lo]};
            end else begin
                resp_q <= 1'b0;
                if (!read_i && !write_i) begin
                    beat_q <= '0; // ready for the next burst
                end
            end
        end
    end

endmodule : burst_mem_model

// ==== verif/mem_sys_tb.sv ====
`timescale 1ns/10ps

module mem_sys_tb;
    import mem_sys_pkg::*;

    localparam int    NUM_SETS       = 8;
    localparam int    MEM_WORDS      = 1024;    // 4 KB behind bmem
    localparam int    TIMEOUT_CYCLES = 4000;    // ~35 accesses at 30 cycles worst case
    localparam word_t IMEM_BASE      = 32'h800; // fetch region, never stored to

    logic  clk = 1'b0;
    logic  rst_n_i;
    word_t imem_addr_i;
    logic  imem_read_i;
    word_t imem_rdata_o;
    logic  imem_resp_o;
    word_t dmem_addr_i;
    logic  dmem_read_i;
    logic  dmem_write_i;
    mask_t dmem_wmask_i;
    word_t dmem_wdata_i;
    word_t dmem_rdata_o;
    logic  dmem_resp_o;
    word_t bmem_addr_o;
    logic  bmem_read_o;
    logic  bmem_write_o;
    beat_t bmem_wdata_o;
    beat_t bmem_rdata_i;
    logic  bmem_resp_i;

    word_t ref_mem [MEM_WORDS]; // expected memory image, stores applied as issued
    int    errors         = 0;
    int    checks         = 0;
    int    cycle_count    = 0;
    int    bmem_rd_cycles = 0;
    int    bmem_wr_cycles = 0;

    always #5 clk = ~clk;

    mem_sys_top #(
        .NUM_SETS (NUM_SETS)
    ) DUT (.*);

    burst_mem_model #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_model (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .addr_i  (bmem_addr_o),
        .read_i  (bmem_read_o),
        .write_i (bmem_write_o),
        .wdata_i (bmem_wdata_o),
        .rdata_o (bmem_rdata_i),
        .resp_o  (bmem_resp_i)
    );

    always @(posedge clk) begin
        if (bmem_read_o) bmem_rd_cycles <= bmem_rd_cycles + 1;
        if (bmem_write_o) bmem_wr_cycles <= bmem_wr_cycles + 1;
    end

    task automatic check_val(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic word_t ref_word(input word_t addr);
        return ref_mem[addr[11:2]];
    endfunction

    function automatic void apply_store(input word_t addr, input mask_t mask, input word_t data);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) ref_mem[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
        end
    endfunction

    // lat counts the request's first cycle as 1
    task automatic imem_read(input string name, input word_t addr, output int lat);
        word_t got;
        imem_addr_i = addr;
        imem_read_i = 1'b1;
        lat = 1;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!imem_resp_o);
        got = imem_rdata_o;
        @(posedge clk);
        #1;
        imem_read_i = 1'b0;
        check_val({name, " resp pulse"}, '0, word_t'(imem_resp_o));
        check_val(name, ref_word(addr), got);
    endtask

    task automatic dmem_read(input string name, input word_t addr, output int lat);
        word_t got;
        dmem_addr_i = addr;
        dmem_read_i = 1'b1;
        lat = 1;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!dmem_resp_o);
        got = dmem_rdata_o;
        @(posedge clk);
        #1;
        dmem_read_i = 1'b0;
        check_val({name, " resp pulse"}, '0, word_t'(dmem_resp_o));
        check_val(name, ref_word(addr), got);
    endtask

    task automatic dmem_write(input string name, input word_t addr, input mask_t mask,
                              input word_t data);
        dmem_addr_i  = addr;
        dmem_wmask_i = mask;
        dmem_wdata_i = data;
        dmem_write_i = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!dmem_resp_o);
        @(posedge clk);
        #1;
        dmem_write_i = 1'b0;
        apply_store(addr, mask, data);
        check_val({name, " resp pulse"}, '0, word_t'(dmem_resp_o));
    endtask

    task automatic after_reset_idle();
        repeat (8) begin
            @(posedge clk);
            #1;
            check_val("idle imem resp", '0, word_t'(imem_resp_o));
            check_val("idle dmem resp", '0, word_t'(dmem_resp_o));
            check_val("idle bmem read", '0, word_t'(bmem_read_o));
            check_val("idle bmem write", '0, word_t'(bmem_write_o));
        end
    endtask

    task automatic hit_after_miss();
        int lat;
        int busy;
        imem_read("imem miss", IMEM_BASE, lat);
        busy = bmem_rd_cycles + bmem_wr_cycles;
        imem_read("imem hit", IMEM_BASE + 32'h14, lat);
        check_val("imem hit latency", 32'd2, word_t'(lat));
        check_val("imem hit bmem idle", word_t'(busy), word_t'(bmem_rd_cycles + bmem_wr_cycles));
    endtask

    task automatic masked_store();
        int lat;
        dmem_write("masked store", 32'h24, 4'b0101, 32'hA5C3_5A3C);
        dmem_read("masked load", 32'h24, lat);
    endtask

    // same index, next tag up
    task automatic dirty_eviction();
        int lat;
        int wr_before;
        wr_before = bmem_wr_cycles;
        dmem_write("evict store", 32'h40, 4'b1111, 32'h1234_ABCD);
        dmem_read("evict conflict load", 32'h40 + word_t'(NUM_SETS * 32), lat);
        dmem_read("evict reread", 32'h40, lat);
        check_val("evict writeback seen", 32'd1, word_t'(bmem_wr_cycles > wr_before));
    endtask

    task automatic concurrent_misses();
        int lat_i;
        int lat_d;
        fork
            imem_read("dual imem", IMEM_BASE + 32'h140, lat_i);
            dmem_read("dual dmem", 32'h384, lat_d);
        join
    endtask

    task automatic random_sweep();
        int    op;
        int    lat;
        word_t addr;
        mask_t mask;
        for (int i = 0; i < 24; i++) begin
            op   = int'($urandom % 3);
            addr = word_t'(($urandom % 16) * 32 + ($urandom % 8) * 4); // 16 lines
            if (op == 0) begin
                imem_read($sformatf("sweep %0d imem", i), IMEM_BASE + addr, lat);
            end else if (op == 1) begin
                dmem_read($sformatf("sweep %0d load", i), addr, lat);
            end else begin
                mask = mask_t'($urandom % 15 + 1);
                dmem_write($sformatf("sweep %0d store", i), addr, mask, $urandom);
            end
        end
    endtask

    initial begin
        word_t w;
        rst_n_i      = 1'b0;
        imem_addr_i  = '0;
        imem_read_i  = 1'b0;
        dmem_addr_i  = '0;
        dmem_read_i  = 1'b0;
        dmem_write_i = 1'b0;
        dmem_wmask_i = '0;
        dmem_wdata_i = '0;
        void'($urandom(32'h8767));
        for (int i = 0; i < MEM_WORDS; i++) begin
            w             = $urandom;
            ref_mem[i]    = w;
            mem_model.mem[i] = w;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        after_reset_idle();
        hit_after_miss();
        masked_store();
        dirty_eviction();
        concurrent_misses();
        random_sweep();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run timed out after %0d cycles with %0d errors", TIMEOUT_CYCLES, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule : mem_sys_tb

// ==== files.f ====
rtl/mem_sys_pkg.sv
rtl/line_if.sv
rtl/cache.sv
rtl/cache_arbiter.sv
rtl/cacheline_adaptor.sv
rtl/mem_sys_top.sv
verif/burst_mem_model.sv
verif/mem_sys_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module mem_sys_tb -f files.f -o mem_sys_sim \
    && ./obj_dir/mem_sys_sim | tee /dev/stderr | grep -qx "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
